/* design/spi_defines.svh */
`ifndef SPI_DEFINES_SVH
`define SPI_DEFINES_SVH

//////////////////////////////
// Transfer geometry
//////////////////////////////

// Bits shifted per transfer
`define SPI_WIDTH 32

// Lane engines in the array
`define SPI_LANES 4

// Width of a lane number
`define SPI_LANE_BITS 2

//////////////////////////////
// SCK timing
//////////////////////////////

// System clocks per SCK half period, 12.5 MHz SCK
`define SPI_DIV 2

`endif

/* design/spi_pkg.sv */
`include "spi_defines.svh"

package spi_pkg;

	// One SPI word, MSB goes out first
	typedef logic [`SPI_WIDTH-1:0] spi_word_t;

	// Host command, lane number on top
	typedef struct packed {
		logic [`SPI_LANE_BITS-1:0] lane;
		spi_word_t                 data;
	} spi_cmd_t;

	// Host response, word read back from MISO
	typedef struct packed {
		logic [`SPI_LANE_BITS-1:0] lane;
		spi_word_t                 data;
	} spi_rsp_t;

	// Lane engine states
	typedef enum logic [1:0] {
		LANE_IDLE,
		LANE_SHIFT,
		LANE_FINISH,
		LANE_REPORT
	} spi_lane_state_t;

endpackage

/* design/spi_sck_gen.sv */
`timescale 1ns/1ps
`include "spi_defines.svh"

module spi_sck_gen (
	input  logic CLK50MHZ,
	input  logic RST,
	input  logic start,
	input  logic run,
	output logic sck_level,
	output logic sck_rise,
	output logic sck_fall
);

	localparam int CNT_BITS = $clog2(`SPI_DIV + 1);
	localparam logic [CNT_BITS-1:0] CNT_LAST = CNT_BITS'(`SPI_DIV - 1);

	logic [CNT_BITS-1:0] cnt;
	logic                half_done;

	// Last system clock of a half period
	assign half_done = run && !start && (cnt == CNT_LAST);

	// Strobes mark the clock whose edge flips the level
	assign sck_rise = half_done && !sck_level;
	assign sck_fall = half_done && sck_level;

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			cnt       <= '0;
			sck_level <= 1'b0;
		end else if (start || !run) begin
			// Same phase for every transfer, SCK parked low
			cnt       <= '0;
			sck_level <= 1'b0;
		end else if (half_done) begin
			cnt       <= '0;
			sck_level <= ~sck_level;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

/* design/spi_lane.sv */
`timescale 1ns/1ps
`include "spi_defines.svh"

module spi_lane (
	input  logic               CLK50MHZ,
	input  logic               RST,
	input  logic               lane_req,
	input  spi_pkg::spi_word_t lane_data,
	output logic               lane_ack,
	output logic               res_req,
	input  logic               res_ack,
	output spi_pkg::spi_word_t res_data,
	output logic               spi_sck,
	output logic               spi_cs,
	output logic               spi_mosi,
	input  logic               spi_miso
);

	import spi_pkg::*;

	localparam int BIT_BITS = $clog2(`SPI_WIDTH);
	localparam logic [BIT_BITS-1:0] BIT_LAST = BIT_BITS'(`SPI_WIDTH - 1);

	spi_lane_state_t     state;
	spi_word_t           shreg;
	logic [BIT_BITS-1:0] bit_idx;
	logic                miso_bit;
	logic                take;
	logic                start;
	logic                run;
	logic                sck_rise;
	logic                sck_fall;
	logic                last_bit;

	// New command accepted only from idle
	assign take = (state == LANE_IDLE) && lane_req && !lane_ack;

	// First SHIFT cycle still has CS high
	assign start    = (state == LANE_SHIFT) && spi_cs;
	assign run      = (state == LANE_SHIFT) && !spi_cs;
	assign last_bit = sck_fall && (bit_idx == BIT_LAST);

	assign res_data = shreg;

	spi_sck_gen i_sck_gen (
		.CLK50MHZ  (CLK50MHZ),
		.RST       (RST),
		.start     (start),
		.run       (run),
		.sck_level (spi_sck),
		.sck_rise  (sck_rise),
		.sck_fall  (sck_fall)
	);

	//////////////////////////////
	// Control
	//////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state    <= LANE_IDLE;
			lane_ack <= 1'b0;
			res_req  <= 1'b0;
			spi_cs   <= 1'b1;
			spi_mosi <= 1'b0;
			bit_idx  <= '0;
		end else begin
			// Command handshake closes on its own
			if (lane_ack && !lane_req)
				lane_ack <= 1'b0;

			case (state)
				LANE_IDLE: begin
					if (take) begin
						lane_ack <= 1'b1;
						state    <= LANE_SHIFT;
					end
				end
				LANE_SHIFT: begin
					if (start) begin
						spi_cs   <= 1'b0;
						spi_mosi <= shreg[`SPI_WIDTH-1];
						bit_idx  <= '0;
					end else if (last_bit) begin
						spi_cs   <= 1'b1;
						spi_mosi <= 1'b0;
						state    <= LANE_FINISH;
					end else if (sck_fall) begin
						// Next bit is the one moving up into the MSB
						spi_mosi <= shreg[`SPI_WIDTH-2];
						bit_idx  <= bit_idx + 1'b1;
					end
				end
				LANE_FINISH: begin
					res_req <= 1'b1;
					state   <= LANE_REPORT;
				end
				LANE_REPORT: begin
					if (res_req && res_ack)
						res_req <= 1'b0;
					else if (!res_req && !res_ack)
						state <= LANE_IDLE;
				end
				default: state <= LANE_IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Data path
	//////////////////////////////

	// TX bits leave at the top while RX bits fill in from the bottom
	always_ff @(posedge CLK50MHZ) begin
		if (take)
			shreg <= lane_data;
		else if (run && sck_fall)
			shreg <= {shreg[`SPI_WIDTH-2:0], miso_bit};

		if (run && sck_rise)
			miso_bit <= spi_miso;
	end

endmodule

/* design/spi_dispatch.sv */
`timescale 1ns/1ps
`include "spi_defines.svh"

module spi_dispatch (
	input  logic               CLK50MHZ,
	input  logic               RST,
	input  logic               cmd_req,
	input  spi_pkg::spi_cmd_t  cmd,
	output logic               cmd_ack,
	output logic               lane_req [`SPI_LANES],
	output spi_pkg::spi_word_t lane_data,
	input  logic               lane_ack [`SPI_LANES]
);

	typedef enum logic [1:0] {
		DISP_IDLE,
		DISP_LANE,
		DISP_HOLD,
		DISP_CLOSE
	} disp_state_t;

	disp_state_t               state;
	logic [`SPI_LANE_BITS-1:0] sel;
	logic                      req_open;
	logic                      sel_ack;

	assign sel_ack = lane_ack[sel];

	// One-hot request towards the addressed lane
	always_comb begin
		for (int i = 0; i < `SPI_LANES; i++)
			lane_req[i] = req_open && (sel == `SPI_LANE_BITS'(i));
	end

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state    <= DISP_IDLE;
			sel      <= '0;
			req_open <= 1'b0;
			cmd_ack  <= 1'b0;
		end else begin
			case (state)
				DISP_IDLE: begin
					if (cmd_req) begin
						sel      <= cmd.lane;
						req_open <= 1'b1;
						state    <= DISP_LANE;
					end
				end
				// Waits here while the lane is busy
				DISP_LANE: begin
					if (sel_ack) begin
						cmd_ack <= 1'b1;
						state   <= DISP_HOLD;
					end
				end
				DISP_HOLD: begin
					if (!cmd_req) begin
						req_open <= 1'b0;
						state    <= DISP_CLOSE;
					end
				end
				DISP_CLOSE: begin
					if (!sel_ack) begin
						cmd_ack <= 1'b0;
						state   <= DISP_IDLE;
					end
				end
				default: state <= DISP_IDLE;
			endcase
		end
	end

	// Word held stable for the lane
	always_ff @(posedge CLK50MHZ) begin
		if (state == DISP_IDLE && cmd_req)
			lane_data <= cmd.data;
	end

endmodule

/* design/spi_collect.sv */
`timescale 1ns/1ps
`include "spi_defines.svh"

module spi_collect (
	input  logic               CLK50MHZ,
	input  logic               RST,
	input  logic               res_req [`SPI_LANES],
	input  spi_pkg::spi_word_t res_data [`SPI_LANES],
	output logic               res_ack [`SPI_LANES],
	output logic               rsp_req,
	output spi_pkg::spi_rsp_t  rsp,
	input  logic               rsp_ack
);

	typedef enum logic [1:0] {
		COL_IDLE,
		COL_HOST,
		COL_DRAIN
	} col_state_t;

	col_state_t                state;
	logic [`SPI_LANE_BITS-1:0] cur;
	logic [`SPI_LANE_BITS-1:0] cand;
	logic [`SPI_LANE_BITS-1:0] pick;
	logic                      pick_ok;
	logic                      ack_open;

	// Search starts one past the lane served last
	always_comb begin
		cand    = cur;
		pick    = cur;
		pick_ok = 1'b0;
		for (int k = 1; k <= `SPI_LANES; k++) begin
			cand = cur + `SPI_LANE_BITS'(k);
			if (!pick_ok && res_req[cand]) begin
				pick    = cand;
				pick_ok = 1'b1;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < `SPI_LANES; i++)
			res_ack[i] = ack_open && (cur == `SPI_LANE_BITS'(i));
	end

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state    <= COL_IDLE;
			cur      <= `SPI_LANE_BITS'(`SPI_LANES - 1);
			rsp_req  <= 1'b0;
			ack_open <= 1'b0;
		end else begin
			case (state)
				COL_IDLE: begin
					if (pick_ok) begin
						cur     <= pick;
						rsp_req <= 1'b1;
						state   <= COL_HOST;
					end
				end
				// Host ack passed on to the lane
				COL_HOST: begin
					if (rsp_ack) begin
						rsp_req  <= 1'b0;
						ack_open <= 1'b1;
						state    <= COL_DRAIN;
					end
				end
				COL_DRAIN: begin
					if (ack_open) begin
						if (!res_req[cur])
							ack_open <= 1'b0;
					end else if (!rsp_ack) begin
						state <= COL_IDLE;
					end
				end
				default: state <= COL_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK50MHZ) begin
		if (state == COL_IDLE && pick_ok) begin
			rsp.lane <= pick;
			rsp.data <= res_data[pick];
		end
	end

endmodule

/* design/spi_array.sv */
`timescale 1ns/1ps
`include "spi_defines.svh"

module spi_array (
	input  logic              CLK50MHZ,
	input  logic              RST,
	input  logic              cmd_req,
	input  spi_pkg::spi_cmd_t cmd,
	output logic              cmd_ack,
	output logic              rsp_req,
	output spi_pkg::spi_rsp_t rsp,
	input  logic              rsp_ack,
	output logic              spi_sck [`SPI_LANES],
	output logic              spi_cs [`SPI_LANES],
	output logic              spi_mosi [`SPI_LANES],
	input  logic              spi_miso [`SPI_LANES]
);

	import spi_pkg::*;

	logic      lane_req [`SPI_LANES];
	logic      lane_ack [`SPI_LANES];
	spi_word_t lane_data;
	logic      res_req [`SPI_LANES];
	logic      res_ack [`SPI_LANES];
	spi_word_t res_data [`SPI_LANES];

	spi_dispatch i_dispatch (
		.CLK50MHZ  (CLK50MHZ),
		.RST       (RST),
		.cmd_req   (cmd_req),
		.cmd       (cmd),
		.cmd_ack   (cmd_ack),
		.lane_req  (lane_req),
		.lane_data (lane_data),
		.lane_ack  (lane_ack)
	);

	for (genvar i = 0; i < `SPI_LANES; i++) begin : g_lane
		spi_lane i_lane (
			.CLK50MHZ  (CLK50MHZ),
			.RST       (RST),
			.lane_req  (lane_req[i]),
			.lane_data (lane_data),
			.lane_ack  (lane_ack[i]),
			.res_req   (res_req[i]),
			.res_ack   (res_ack[i]),
			.res_data  (res_data[i]),
			.spi_sck   (spi_sck[i]),
			.spi_cs    (spi_cs[i]),
			.spi_mosi  (spi_mosi[i]),
			.spi_miso  (spi_miso[i])
		);
	end

	spi_collect i_collect (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.res_req  (res_req),
		.res_data (res_data),
		.res_ack  (res_ack),
		.rsp_req  (rsp_req),
		.rsp      (rsp),
		.rsp_ack  (rsp_ack)
	);

endmodule

/* bench/spi_bench_clock.sv */
`timescale 1ns/1ps

module spi_bench_clock (
	output logic CLK50MHZ,
	output logic RST
);

	logic clk     = 1'b0;
	logic rst     = 1'b1;
	int   rst_cnt = 0;

	assign CLK50MHZ = clk;
	assign RST      = rst;

	// 20 ns period
	always #10 clk = ~clk;

	// Reset held over the first 4 rising edges
	always @(posedge clk) begin
		if (rst_cnt < 4)
			rst_cnt <= rst_cnt + 1;
		if (rst_cnt == 3)
			rst <= 1'b0;
	end

endmodule

/* bench/spi_slave_model.sv */
`timescale 1ns/1ps
`include "spi_defines.svh"

module spi_slave_model (
	input  logic                  sck,
	input  logic                  cs,
	input  logic                  mosi,
	output logic                  miso,
	output logic [`SPI_WIDTH-1:0] word
);

	logic [`SPI_WIDTH-1:0] sreg     = '0;
	logic                  mosi_bit = 1'b0;
	logic                  pending  = 1'b0;

	// Old contents go out MSB first
	assign miso = sreg[`SPI_WIDTH-1];
	assign word = sreg;

	//////////////////////////////
	// Mode 0 slave
	//////////////////////////////

	always @(posedge sck or negedge sck) begin
		if (sck) begin
			// Sample on the rising edge, only while selected
			if (!cs) begin
				mosi_bit <= mosi;
				pending  <= 1'b1;
			end
		end else begin
			// Shift on the falling edge that follows a sample
			if (pending) begin
				sreg    <= {sreg[`SPI_WIDTH-2:0], mosi_bit};
				pending <= 1'b0;
			end
		end
	end

	// A full transfer leaves the received word in sreg,
	// so the next transfer on this lane sends it back

endmodule

/* bench/spi_bench.sv */
`timescale 1ns/1ps
`include "spi_defines.svh"

module spi_bench;

	import spi_pkg::*;

	localparam int NUM_CMDS       = 200;
	localparam int XFER_CYCLES    = 2 * `SPI_WIDTH * `SPI_DIV + 20;
	localparam int TIMEOUT_CYCLES = NUM_CMDS * XFER_CYCLES;

	logic            CLK50MHZ;
	logic            RST;
	logic            cmd_req;
	spi_cmd_t        cmd;
	logic            cmd_ack;
	logic            rsp_req;
	spi_rsp_t        rsp;
	logic            rsp_ack;
	logic            spi_sck [`SPI_LANES];
	logic            spi_cs [`SPI_LANES];
	logic            spi_mosi [`SPI_LANES];
	logic            spi_miso [`SPI_LANES];
	spi_word_t       slave_word [`SPI_LANES];
	spi_lane_state_t lane_state [`SPI_LANES];

	// Reference model
	spi_word_t rsp_q [`SPI_LANES][$];
	spi_word_t mosi_q [`SPI_LANES][$];
	spi_word_t last_word [`SPI_LANES];

	logic [31:0] lfsr       = 32'h5bd0b329;
	logic [31:0] delay_lfsr = 32'h5bd0b329;
	int          err_value = 0;
	int          err_proto = 0;
	int          rsp_count = 0;
	int          cycles    = 0;
	logic        rst_d     = 1'b0;
	logic        rst_dd    = 1'b0;
	logic        cs_prev [`SPI_LANES];
	logic        sck_prev [`SPI_LANES];
	int          rise_cnt [`SPI_LANES];

	spi_bench_clock i_clock (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST)
	);

	spi_array i_dut (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.cmd_req  (cmd_req),
		.cmd      (cmd),
		.cmd_ack  (cmd_ack),
		.rsp_req  (rsp_req),
		.rsp      (rsp),
		.rsp_ack  (rsp_ack),
		.spi_sck  (spi_sck),
		.spi_cs   (spi_cs),
		.spi_mosi (spi_mosi),
		.spi_miso (spi_miso)
	);

	for (genvar g = 0; g < `SPI_LANES; g++) begin : g_slave
		spi_slave_model i_slave (
			.sck  (spi_sck[g]),
			.cs   (spi_cs[g]),
			.mosi (spi_mosi[g]),
			.miso (spi_miso[g]),
			.word (slave_word[g])
		);
		assign lane_state[g] = i_dut.g_lane[g].i_lane.state;
	end

	//////////////////////////////
	// Random source
	//////////////////////////////

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// Each process steps its own state
	function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
		logic [31:0] bits;
		bits = '0;
		for (int k = 0; k < n; k++) begin
			state = lfsr_next(state);
			bits  = {bits[30:0], state[0]};
		end
		return bits;
	endfunction

	//////////////////////////////
	// Host side
	//////////////////////////////

	task automatic send_command(input logic [`SPI_LANE_BITS-1:0] lane, input spi_word_t data);
		cmd_req   <= 1'b1;
		cmd.lane  <= lane;
		cmd.data  <= data;
		rsp_q[lane].push_back(last_word[lane]);
		mosi_q[lane].push_back(data);
		last_word[lane] = data;
		do @(posedge CLK50MHZ); while (!cmd_ack);
		cmd_req <= 1'b0;
		do @(posedge CLK50MHZ); while (cmd_ack);
	endtask

	task automatic check_response(input spi_rsp_t r);
		spi_word_t expected;
		rsp_count++;
		assert (rsp_q[r.lane].size() > 0) else begin
			err_proto++;
			$display("Unexpected response on lane %0d at %0t with no command outstanding",
				r.lane, $time);
		end
		if (rsp_q[r.lane].size() > 0) begin
			expected = rsp_q[r.lane].pop_front();
			assert (r.data == expected) else begin
				err_value++;
				$display("[ERROR] %0t lane %0d response %h, expected %h",
					$time, r.lane, r.data, expected);
			end
		end
	endtask

	task automatic check_idle_outputs();
		for (int i = 0; i < `SPI_LANES; i++) begin
			assert (spi_cs[i] === 1'b1 && spi_sck[i] === 1'b0 && spi_mosi[i] === 1'b0) else begin
				err_value++;
				$display("[ERROR] %0t lane %0d not idle at reset, cs=%b sck=%b mosi=%b",
					$time, i, spi_cs[i], spi_sck[i], spi_mosi[i]);
			end
		end
		assert (cmd_ack === 1'b0 && rsp_req === 1'b0) else begin
			err_value++;
			$display("[ERROR] %0t handshake active at reset, cmd_ack=%b rsp_req=%b",
				$time, cmd_ack, rsp_req);
		end
	endtask

	initial begin : host_side
		logic [31:0]               bits;
		logic [`SPI_LANE_BITS-1:0] lane;
		spi_word_t                 data;
		cmd_req = 1'b0;
		cmd     = '0;
		for (int i = 0; i < `SPI_LANES; i++)
			last_word[i] = '0;
		do @(posedge CLK50MHZ); while (RST);
		for (int n = 0; n < NUM_CMDS; n++) begin
			bits = take_bits(lfsr, `SPI_LANE_BITS);
			lane = bits[`SPI_LANE_BITS-1:0];
			data = take_bits(lfsr, `SPI_WIDTH);
			send_command(lane, data);
		end
		do @(posedge CLK50MHZ); while (rsp_count < NUM_CMDS);
		// Room for a stray extra response
		repeat (XFER_CYCLES) @(posedge CLK50MHZ);
		assert (rsp_count == NUM_CMDS) else begin
			err_proto++;
			$display("Received %0d responses for %0d commands", rsp_count, NUM_CMDS);
		end
		for (int i = 0; i < `SPI_LANES; i++) begin
			assert (rsp_q[i].size() == 0 && mosi_q[i].size() == 0) else begin
				err_proto++;
				$display("Lane %0d left %0d responses and %0d transfers outstanding",
					i, rsp_q[i].size(), mosi_q[i].size());
			end
		end
		$display("Checks done: %0d value errors, %0d protocol errors, %0d of %0d responses",
			err_value, err_proto, rsp_count, NUM_CMDS);
		if (err_value == 0 && err_proto == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// Host answers each response after 0 to 7 cycles
	initial begin : response_side
		logic [31:0] delay;
		rsp_ack = 1'b0;
		do @(posedge CLK50MHZ); while (RST);
		forever begin
			@(posedge CLK50MHZ);
			if (rsp_req && !rsp_ack) begin
				check_response(rsp);
				delay = take_bits(delay_lfsr, 3);
				repeat (delay) @(posedge CLK50MHZ);
				rsp_ack <= 1'b1;
				do @(posedge CLK50MHZ); while (rsp_req);
				rsp_ack <= 1'b0;
			end
		end
	end

	//////////////////////////////
	// Lane monitors
	//////////////////////////////

	always @(posedge CLK50MHZ) begin
		if (rst_d || rst_dd)
			check_idle_outputs();
		if (!RST && !rst_d) begin
			for (int i = 0; i < `SPI_LANES; i++) begin
				if (cs_prev[i] && !spi_cs[i]) begin
					assert (mosi_q[i].size() > 0) else begin
						err_proto++;
						$display("CS of lane %0d fell at %0t without a command, state %s",
							i, $time, lane_state[i].name());
					end
					rise_cnt[i] = 0;
				end
				assert (!(spi_sck[i] && spi_cs[i])) else begin
					err_proto++;
					$display("SCK of lane %0d high at %0t while CS is high", i, $time);
				end
				if (spi_sck[i] && !sck_prev[i])
					rise_cnt[i]++;
				// Slave holds the received word once the transfer closes
				if (!cs_prev[i] && spi_cs[i]) begin
					assert (rise_cnt[i] == `SPI_WIDTH) else begin
						err_value++;
						$display("[ERROR] %0t lane %0d saw %0d SCK rises, expected %0d",
							$time, i, rise_cnt[i], `SPI_WIDTH);
					end
					if (mosi_q[i].size() > 0) begin
						assert (slave_word[i] == mosi_q[i][0]) else begin
							err_value++;
							$display("[ERROR] %0t lane %0d slave got %h, expected %h",
								$time, i, slave_word[i], mosi_q[i][0]);
						end
						void'(mosi_q[i].pop_front());
					end
				end
			end
		end
		for (int i = 0; i < `SPI_LANES; i++) begin
			cs_prev[i]  = spi_cs[i];
			sck_prev[i] = spi_sck[i];
		end
		rst_dd <= rst_d;
		rst_d  <= RST;
	end

	// Watchdog
	always @(posedge CLK50MHZ) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles with %0d of %0d responses received",
				cycles, rsp_count, NUM_CMDS);
			$display("Simulation FAILED");
			$finish;
		end
	end

endmodule

/* filelist.f */
+incdir+design
design/spi_pkg.sv
design/spi_sck_gen.sv
design/spi_lane.sv
design/spi_dispatch.sv
design/spi_collect.sv
design/spi_array.sv
bench/spi_bench_clock.sv
bench/spi_slave_model.sv
bench/spi_bench.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f filelist.f --top-module spi_bench
	@out=$$(./obj_dir/Vspi_bench); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf obj_dir
